// File: u712Pkg.sv
package u712Pkg;

    //////////////////////////////////////////////////
    // Bus geometry
    //////////////////////////////////////////////////

    localparam int addrWidth = 32;  // Full 68040 address bus
    localparam int dataWidth = 32;  // Long word data bus

    // A line transfer always moves four long words
    localparam int burstBeats = 4;

    //////////////////////////////////////////////////
    // Transfer size field
    //////////////////////////////////////////////////

    // Encoding of the two SIZ pins as the CPU drives them
    typedef enum logic [1:0] {
        sizeLong = 2'b00,   // Four bytes
        sizeByte = 2'b01,   // One byte
        sizeWord = 2'b10,   // Two bytes
        sizeLine = 2'b11    // Sixteen bytes, asks for a burst
    } sizeCode;

    //////////////////////////////////////////////////
    // Responder state machines
    //////////////////////////////////////////////////

    // Register space has a fixed wait and a single beat
    typedef enum logic [1:0] {
        regIdle,    // Waiting for register space
        regWait,    // Counting wait states
        regAck      // The one beat of the cycle
    } regState;

    // RAM space adds a beat phase and a one cycle recovery
    typedef enum logic [1:0] {
        ramIdle,    // Waiting for RAM space
        ramWait,    // Access latency before the first beat
        ramBeat,    // One beat per clock until the last
        ramDone     // Space is released here
    } ramState;

endpackage

// File: cycleDecode.sv
`timescale 1ns/10ps

module cycleDecode #(
    parameter logic [7:0] REG_BASE = 8'hDA
) (
    input  logic                          CLK40,
    input  logic                          nRESET,
    input  logic                          nTS,
    input  logic [u712Pkg::addrWidth-1:0] addr,
    input  logic                          rnW,
    input  u712Pkg::sizeCode              siz,
    input  logic [u712Pkg::dataWidth-1:0] writeData,
    input  logic                          regTa,
    input  logic                          ramDone,
    input  logic                          burstStop,
    output logic                          nRegSpace,
    output logic                          nRamSpace,
    output logic                          burstCycle,
    output logic [u712Pkg::addrWidth-1:0] cycleAddr,
    output logic                          cycleRnW,
    output logic [u712Pkg::dataWidth-1:0] cycleData
);
    import u712Pkg::*;

    localparam int RAM_WORDS = 64;
    // RAM space mirrors every RAM_WORDS long words
    localparam logic [addrWidth-1:0] ramAddrMask = addrWidth'(RAM_WORDS * 4 - 1);

    logic idle;        // No cycle in progress
    logic regHit;
    logic ramHit;
    logic burstLevel;  // Registered burst flag

    assign idle   = nRegSpace && nRamSpace;
    assign regHit = addr[addrWidth-1 -: 8] == REG_BASE;  // Top byte picks registers
    assign ramHit = addr[addrWidth-1 -: 4] == 4'h0;      // Lowest 256M is RAM

    // A DMA cut drops the burst in the beat itself so that beat is burst inhibited
    assign burstCycle = burstLevel && !burstStop;

    //////////////////////////////////////////////////
    // Space levels
    //////////////////////////////////////////////////

    always_ff @(posedge CLK40, negedge nRESET) begin
        if (!nRESET) begin
            nRegSpace  <= 1'b1;
            nRamSpace  <= 1'b1;
            burstLevel <= 1'b0;
        end else if (idle) begin
            if (!nTS) begin  // Unmapped cycles leave both spaces high
                nRegSpace  <= !regHit;
                nRamSpace  <= !ramHit;
                burstLevel <= ramHit && (siz == sizeLine);
            end
        end else begin
            if (regTa) begin
                nRegSpace <= 1'b1;  // Single beat, so the cycle is over
            end
            if (ramDone) begin
                nRamSpace  <= 1'b1;
                burstLevel <= 1'b0;
            end
        end
    end

    // The cycle payload is taken with the strobe and held for the responders
    always_ff @(posedge CLK40) begin
        if (idle && !nTS) begin
            cycleAddr <= ramHit ? (addr & ramAddrMask) : addr;
            cycleRnW  <= rnW;
            cycleData <= writeData;
        end
    end

    // Both responders would drive the bus at once
    spacesExclusive: assert property (@(posedge CLK40) disable iff (!nRESET)
        nRegSpace || nRamSpace);

    // The CPU started a new cycle before the last one was acknowledged
    strobeWhileBusy: assert property (@(posedge CLK40) disable iff (!nRESET)
        !nTS |-> idle)
        else $error("nTS asserted while a cycle is still open");

endmodule

// File: regResponder.sv
`timescale 1ns/10ps

module regResponder #(
    parameter int REG_WAIT = 2
) (
    input  logic                          CLK40,
    input  logic                          nRESET,
    input  logic                          nRegSpace,
    input  logic [u712Pkg::addrWidth-1:0] cycleAddr,
    input  logic                          cycleRnW,
    input  logic [u712Pkg::dataWidth-1:0] cycleData,
    output logic                          regTa,
    output logic [u712Pkg::dataWidth-1:0] regData
);
    import u712Pkg::*;

    // Wide enough to reach REG_WAIT plus one
    localparam int cntBits = $clog2(REG_WAIT + 2);

    regState              state;
    logic [cntBits-1:0]   waitCnt;
    logic [1:0]           regSel;        // Long word within the register block
    logic [dataWidth-1:0] regFile [4];

    assign regSel  = cycleAddr[3:2];
    assign regTa   = state == regAck;  // Exactly one clock per cycle
    assign regData = regFile[regSel];  // Valid throughout the ack cycle

    //////////////////////////////////////////////////
    // Wait state counter
    //////////////////////////////////////////////////

    // The space goes low on the strobe edge, so the first count lands one edge later
    always_ff @(posedge CLK40, negedge nRESET) begin
        if (!nRESET) begin
            state   <= regIdle;
            waitCnt <= '0;
        end else begin
            case (state)
                regIdle: begin
                    if (!nRegSpace) begin
                        waitCnt <= cntBits'(1);
                        state   <= (REG_WAIT == 0) ? regAck : regWait;
                    end
                end
                regWait: begin
                    if (waitCnt >= cntBits'(REG_WAIT)) begin
                        state <= regAck;
                    end else begin
                        waitCnt <= waitCnt + cntBits'(1);
                    end
                end
                regAck:  state <= regIdle;  // Decoder drops the space on this edge
                default: state <= regIdle;
            endcase
        end
    end

    // SIZ is ignored here, every register access moves a full long word
    always_ff @(posedge CLK40) begin
        if (regTa && !cycleRnW) begin
            regFile[regSel] <= cycleData;
        end
    end

    // An ack with no register cycle open would end someone else's transfer
    regTaInSpace: assert property (@(posedge CLK40) disable iff (!nRESET)
        regTa |-> !nRegSpace);

endmodule

// File: ramResponder.sv
`timescale 1ns/10ps

module ramResponder #(
    parameter int RAM_WAIT = 3
) (
    input  logic                          CLK40,
    input  logic                          nRESET,
    input  logic                          nRamSpace,
    input  logic                          burstCycle,
    input  logic [u712Pkg::addrWidth-1:0] cycleAddr,
    input  logic                          cycleRnW,
    input  logic [u712Pkg::dataWidth-1:0] cycleData,
    input  logic                          dmaReq,
    output logic                          ramTa,
    output logic                          ramDone,
    output logic                          burstStop,
    output logic [u712Pkg::dataWidth-1:0] ramData
);
    import u712Pkg::*;

    localparam int cntBits  = $clog2(RAM_WAIT + 2);
    localparam int wordBits = 6;                          // 64 long words, as decoded
    localparam logic [1:0] lastIdx = 2'(burstBeats - 1);  // Beat number of a full line end

    ramState              state;
    logic [cntBits-1:0]   waitCnt;
    logic [1:0]           beatCnt;     // Beats already given in this cycle
    logic                 isBurst;     // Burst flag taken when the cycle starts
    logic                 lastBeat;
    logic [1:0]           lineWord;    // Wrapping word inside the line
    logic [wordBits-1:0]  wordIdx;
    logic [2:0]           taCount;     // Acks seen in the open cycle
    logic [dataWidth-1:0] mem [2**wordBits];

    assign ramTa     = state == ramBeat;
    assign burstStop = ramTa && isBurst && dmaReq;  // DMA takes the bus after this beat
    assign lastBeat  = !isBurst || dmaReq || (beatCnt == lastIdx);
    assign ramDone   = ramTa && lastBeat;

    // Bits 3..2 plus the beat count wrap inside the 16 byte line, single cycles stay put
    assign lineWord = cycleAddr[3:2] + beatCnt;
    assign wordIdx  = {cycleAddr[wordBits+1:4], lineWord};
    assign ramData  = mem[wordIdx];

    //////////////////////////////////////////////////
    // Access sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge CLK40, negedge nRESET) begin
        if (!nRESET) begin
            state   <= ramIdle;
            waitCnt <= '0;
            beatCnt <= '0;
            isBurst <= 1'b0;
        end else begin
            case (state)
                ramIdle: begin
                    if (!nRamSpace) begin
                        waitCnt <= cntBits'(1);
                        beatCnt <= '0;
                        isBurst <= burstCycle;  // Never cut yet at this point
                        state   <= (RAM_WAIT == 0) ? ramBeat : ramWait;
                    end
                end
                ramWait: begin
                    if (waitCnt >= cntBits'(RAM_WAIT)) begin
                        state <= ramBeat;
                    end else begin
                        waitCnt <= waitCnt + cntBits'(1);
                    end
                end
                ramBeat: begin
                    // The enum value shares its name with the ramDone port
                    if (lastBeat) begin
                        state <= u712Pkg::ramDone;
                    end else begin
                        beatCnt <= beatCnt + 2'd1;
                    end
                end
                u712Pkg::ramDone: state <= ramIdle;  // Space is already high here
                default:          state <= ramIdle;
            endcase
        end
    end

    // Each write beat stores the same latched long word
    always_ff @(posedge CLK40) begin
        if (ramTa && !cycleRnW) begin
            mem[wordIdx] <= cycleData;
        end
    end

    // Counts acks against the space held by the decoder
    always_ff @(posedge CLK40, negedge nRESET) begin
        if (!nRESET) begin
            taCount <= '0;
        end else if (nRamSpace) begin
            taCount <= '0;
        end else if (ramTa) begin
            taCount <= taCount + 3'd1;
        end
    end

    // A line is four beats at most, whatever the decoder does with the space
    beatLimit: assert property (@(posedge CLK40) disable iff (!nRESET)
        ramTa |-> taCount < 3'(burstBeats));

endmodule

// File: transferAck.sv
`timescale 1ns/10ps

module transferAck (
    input  logic CLK40,
    input  logic nRESET,
    input  logic regTa,
    input  logic ramTa,
    input  logic nRegSpace,
    input  logic nRamSpace,
    input  logic burstCycle,
    output logic nTA,
    output logic nTBI,
    output logic taEnable
);

    logic ta;       // Some responder has a beat ready
    logic taSpace;  // A cycle we own is open
    logic taCycle;  // Trailing drive after an ack

    //////////////////////////////////////////////////
    // Acknowledge lines
    //////////////////////////////////////////////////

    assign ta      = regTa || ramTa;
    assign taSpace = !nRegSpace || !nRamSpace;

    // The lines sit high whenever they are driven without a beat
    assign nTA = !ta;

    // Registers never burst, and RAM only bursts while the line is uncut
    assign nTBI = !(regTa || (ramTa && !burstCycle));

    // Unmapped cycles never enable the drivers, so the bus stays floating
    assign taEnable = taSpace || taCycle;

    // Hold the lines high one clock past the last ack so the next cycle can not end early
    always_ff @(posedge CLK40, negedge nRESET) begin
        if (!nRESET) begin
            taCycle <= 1'b0;
        end else begin
            taCycle <= ta && taSpace;
        end
    end

endmodule

// File: u712Top.sv
`timescale 1ns/10ps

module u712Top #(
    parameter logic [7:0] REG_BASE = 8'hDA,  // Top address byte of the registers
    parameter int         REG_WAIT = 2,
    parameter int         RAM_WAIT = 3
) (
    input  logic                          CLK40,
    input  logic                          nRESET,
    input  logic                          nTS,
    input  logic [u712Pkg::addrWidth-1:0] addr,
    input  logic                          rnW,
    input  u712Pkg::sizeCode              siz,
    input  logic [u712Pkg::dataWidth-1:0] writeData,
    input  logic                          dmaReq,
    output logic [u712Pkg::dataWidth-1:0] readData,
    output logic                          nTA,
    output logic                          nTBI,
    output logic                          taEnable
);
    import u712Pkg::*;

    logic                 nRegSpace;
    logic                 nRamSpace;
    logic                 burstCycle;
    logic [addrWidth-1:0] cycleAddr;
    logic                 cycleRnW;
    logic [dataWidth-1:0] cycleData;
    logic                 regTa;
    logic [dataWidth-1:0] regData;
    logic                 ramTa;
    logic                 ramDone;
    logic                 burstStop;
    logic [dataWidth-1:0] ramData;

    // Read data follows whichever space is open
    assign readData = !nRegSpace ? regData : ramData;

    cycleDecode #(
        .REG_BASE (REG_BASE)
    ) cycleDecode_inst (
        .CLK40, .nRESET, .nTS, .addr, .rnW, .siz, .writeData,
        .regTa, .ramDone, .burstStop,
        .nRegSpace, .nRamSpace, .burstCycle, .cycleAddr, .cycleRnW, .cycleData
    );

    regResponder #(
        .REG_WAIT (REG_WAIT)
    ) regResponder_inst (
        .CLK40, .nRESET, .nRegSpace, .cycleAddr, .cycleRnW, .cycleData,
        .regTa, .regData
    );

    ramResponder #(
        .RAM_WAIT (RAM_WAIT)
    ) ramResponder_inst (
        .CLK40, .nRESET, .nRamSpace, .burstCycle, .cycleAddr, .cycleRnW, .cycleData,
        .dmaReq, .ramTa, .ramDone, .burstStop, .ramData
    );

    transferAck transferAck_inst (
        .CLK40, .nRESET, .regTa, .ramTa, .nRegSpace, .nRamSpace, .burstCycle,
        .nTA, .nTBI, .taEnable
    );

endmodule

// File: u712Tb.sv
`timescale 1ns/10ps

module u712Tb;
    import u712Pkg::*;

    localparam int regWait     = 2;   // Default REG_WAIT of the DUT
    localparam int ramWait     = 3;   // Default RAM_WAIT of the DUT
    localparam int cycleLimit  = 16;  // Clocks allowed for one acknowledged cycle
    localparam int noAckCycles = 12;  // Clocks watched on an unmapped cycle

    logic                 CLK40 = 1'b0;
    logic                 nRESET;
    logic                 nTS;
    logic [addrWidth-1:0] addr;
    logic                 rnW;
    sizeCode              siz;
    logic [dataWidth-1:0] writeData;
    logic                 dmaReq;
    logic [dataWidth-1:0] readData;
    logic                 nTA;
    logic                 nTBI;
    logic                 taEnable;

    // Stimulus table, one entry per bus cycle
    logic [31:0] tabAddr [$];
    logic        tabRnW [$];
    sizeCode     tabSiz [$];
    int          tabDma [$];      // Beat that sees dmaReq, or -1
    int          tabBeats [$];
    logic [3:0]  tabTbi [$];      // Bit i is the nTBI level of beat i
    logic        tabNoAck [$];

    logic [31:0] regModel [4];    // Expected register file
    logic [31:0] ramModel [64];   // Expected RAM contents
    logic [31:0] lcgState = 32'hcdc4_281e;
    int          checkCount = 0;
    int          errorCount = 0;
    int          timeoutCount = 0;

    u712Top u712Top_inst (
        .CLK40, .nRESET, .nTS, .addr, .rnW, .siz, .writeData, .dmaReq,
        .readData, .nTA, .nTBI, .taEnable
    );

    always #50 CLK40 = ~CLK40;  // 100 ns period

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
        return lcgState;
    endfunction

    // Word inside the 64 word RAM, wrapping inside the 16 byte line
    function automatic logic [5:0] ramIndex(input logic [31:0] a, input int beat);
        logic [1:0] w;
        w = a[3:2] + 2'(beat);
        return {a[7:4], w};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic addEntry(input logic [31:0] a, input logic r, input sizeCode s,
                            input int dma, input int beats, input logic [3:0] tbi,
                            input logic noAck);
        tabAddr.push_back(a);
        tabRnW.push_back(r);
        tabSiz.push_back(s);
        tabDma.push_back(dma);
        tabBeats.push_back(beats);
        tabTbi.push_back(tbi);
        tabNoAck.push_back(noAck);
    endtask

    //////////////////////////////////////////////////
    // One bus cycle from the table
    //////////////////////////////////////////////////

    task automatic runCycle(input int idx);
        int          n;
        int          beats;
        int          phase;     // 0 waiting, 1 in beats, 2 trailing cycle seen
        int          firstLat;
        logic        done;
        logic        ackSeen;
        logic        isReg;
        logic [31:0] a;
        logic [31:0] wdata;
        logic [31:0] expData;
        a        = tabAddr[idx];
        wdata    = nextRandom();
        isReg    = a[31:24] == 8'hDA;
        firstLat = isReg ? regWait + 1 : ramWait + 1;
        beats    = 0;
        phase    = 0;
        done     = 1'b0;
        ackSeen  = 1'b0;
        @(negedge CLK40);
        addr      = a;
        rnW       = tabRnW[idx];
        siz       = tabSiz[idx];
        writeData = wdata;
        nTS       = 1'b0;
        @(posedge CLK40);  // Edge E takes the strobe
        @(negedge CLK40);
        nTS = 1'b1;
        if (tabNoAck[idx]) begin
            for (n = 1; n <= noAckCycles; n++) begin
                @(posedge CLK40);
                @(negedge CLK40);
                #25;
                if (!nTA && !ackSeen) begin
                    ackSeen = 1'b1;
                    errorCount++;
                    $display("Unmapped address %h was acknowledged at %0t ns", a, $time);
                end
                checkValue("taEnable", 32'(taEnable), 32'(1'b0));  // Bus stays undriven
            end
        end else begin
            for (n = 1; n <= cycleLimit && !done; n++) begin
                @(posedge CLK40);
                @(negedge CLK40);
                dmaReq = (tabDma[idx] >= 0) && (n == firstLat + tabDma[idx]);
                #25;  // Sample in the middle of the low phase
                if (phase == 0 && nTA) begin
                    checkValue("taEnable", 32'(taEnable), 32'(1'b1));
                end else if (phase < 2 && !nTA) begin
                    if (beats == 0) begin
                        checkValue("first beat latency", 32'(n), 32'(firstLat));
                    end
                    phase = 1;
                    if (beats < burstBeats) begin
                        checkValue("nTBI", 32'(nTBI), 32'(tabTbi[idx][beats]));
                    end
                    checkValue("taEnable", 32'(taEnable), 32'(1'b1));
                    expData = isReg ? regModel[a[3:2]] : ramModel[ramIndex(a, beats)];
                    if (tabRnW[idx]) begin
                        checkValue("readData", readData, expData);
                    end else if (isReg) begin
                        regModel[a[3:2]] = wdata;
                    end else begin
                        ramModel[ramIndex(a, beats)] = wdata;  // Every beat takes the word
                    end
                    beats++;
                end else if (phase == 1) begin
                    // First clock after the last beat keeps both lines driven high
                    checkValue("trailing taEnable", 32'(taEnable), 32'(1'b1));
                    checkValue("trailing nTBI", 32'(nTBI), 32'(1'b1));
                    phase = 2;
                end else begin
                    checkValue("taEnable after trailing", 32'(taEnable), 32'(1'b0));
                    checkValue("nTA after trailing", 32'(nTA), 32'(1'b1));
                    done = 1'b1;
                end
            end
            dmaReq = 1'b0;
            if (!done) begin
                timeoutCount++;
                $display("Cycle %0d at address %h did not finish within %0d clocks",
                         idx, a, cycleLimit);
            end
            checkValue("beat count", 32'(beats), 32'(tabBeats[idx]));
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        nRESET    = 1'b0;
        nTS       = 1'b1;
        addr      = '0;
        rnW       = 1'b1;
        siz       = sizeLong;
        writeData = '0;
        dmaReq    = 1'b0;

        // Address          rnW   size      dma beats nTBI     noAck
        addEntry(32'hDA00_0004, 1'b0, sizeLong, -1, 1, 4'b0000, 1'b0);  // Register writes
        addEntry(32'hDA00_000C, 1'b0, sizeWord, -1, 1, 4'b0000, 1'b0);
        addEntry(32'hDA00_0004, 1'b1, sizeLong, -1, 1, 4'b0000, 1'b0);  // And read back
        addEntry(32'hDA00_000C, 1'b1, sizeLine, -1, 1, 4'b0000, 1'b0);
        addEntry(32'h0000_0040, 1'b0, sizeLong, -1, 1, 4'b0000, 1'b0);  // Fill one RAM line
        addEntry(32'h0000_0044, 1'b0, sizeByte, -1, 1, 4'b0000, 1'b0);
        addEntry(32'h0000_0048, 1'b0, sizeLong, -1, 1, 4'b0000, 1'b0);
        addEntry(32'h0000_004C, 1'b0, sizeWord, -1, 1, 4'b0000, 1'b0);
        addEntry(32'h0000_0048, 1'b1, sizeLong, -1, 1, 4'b0000, 1'b0);
        addEntry(32'h0100_0048, 1'b1, sizeLong, -1, 1, 4'b0000, 1'b0);  // Mirrored RAM
        addEntry(32'h0000_0048, 1'b1, sizeLine, -1, 4, 4'b1111, 1'b0);  // Wrapping burst
        addEntry(32'h0000_0084, 1'b0, sizeLine, -1, 4, 4'b1111, 1'b0);
        addEntry(32'h0000_008C, 1'b1, sizeLine, -1, 4, 4'b1111, 1'b0);
        addEntry(32'h0000_0044, 1'b1, sizeLine,  1, 2, 4'b0001, 1'b0);  // DMA cuts
        addEntry(32'h0000_0040, 1'b1, sizeLong, -1, 1, 4'b0000, 1'b0);
        addEntry(32'h0000_0040, 1'b1, sizeLine,  0, 1, 4'b0000, 1'b0);
        addEntry(32'h0000_00C4, 1'b0, sizeLine,  2, 3, 4'b0011, 1'b0);
        addEntry(32'h0000_00C8, 1'b1, sizeLong, -1, 1, 4'b0000, 1'b0);
        addEntry(32'h8000_0000, 1'b1, sizeLong, -1, 0, 4'b0000, 1'b1);  // Unmapped
        addEntry(32'h1234_5678, 1'b0, sizeLine, -1, 0, 4'b0000, 1'b1);
        addEntry(32'hDA00_0004, 1'b1, sizeLong, -1, 1, 4'b0000, 1'b0);

        repeat (2) @(posedge CLK40);
        @(negedge CLK40);
        nRESET = 1'b1;
        #25;
        checkValue("nTA", 32'(nTA), 32'(1'b1));  // Idle levels after reset
        checkValue("nTBI", 32'(nTBI), 32'(1'b1));
        checkValue("taEnable", 32'(taEnable), 32'(1'b0));

        for (int i = 0; i < tabAddr.size(); i++) begin
            runCycle(i);
        end

        $display("Checks: %0d  Errors: %0d  Timeouts: %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
u712Pkg.sv
cycleDecode.sv
regResponder.sv
ramResponder.sv
transferAck.sv
u712Top.sv
u712Tb.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing --assert
TOP        = u712Tb
RTL_TOP    = u712Top
FILELIST   = compile.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
